//--- Makefile
# Verilator build and run of the calculator testbench

SIM = obj_dir/VcalcTb

all: run

$(SIM): sources.f $(wildcard source/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module calcTb -f sources.f

# Pass only when the log holds the pass line
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- source/calcArith.sv
////////////////////////////////////////////////////////////
// Single-cycle add and subtract on register B, with the
// overflow and negative flag registers
////////////////////////////////////////////////////////////

module calcArith (
  input  logic             CLK,
  input  logic             RST,
  input  logic             issueValid,
  input  calcPkg::opcode_t issueOp,
  input  logic             issueSigned,
  input  calcPkg::word_t   regB,
  input  calcPkg::word_t   extOperand,
  output logic             resultValid,
  output calcPkg::word_t   result,
  output logic             overflowFlag,
  output logic             negFlag
);
  import calcPkg::*;

  logic                 isSub;
  logic [dataWidth:0]   sum;
  logic                 carryOut;
  logic                 signedOvf;
  logic                 nextOvf;
  logic                 nextNeg;

  assign isSub = (issueOp == opSub);
  assign resultValid = issueValid && (issueOp == opAdd || isSub);

  // Extra bit holds the carry of an add or the borrow of a subtract
  assign sum = isSub ? ({1'b0, regB} - {1'b0, extOperand})
                     : ({1'b0, regB} + {1'b0, extOperand});
  assign result   = sum[dataWidth-1:0];
  assign carryOut = sum[dataWidth];

  // Two's-complement overflow
  // add: same input signs, result sign differs
  // sub: input signs differ, result sign differs from B
  assign signedOvf = (isSub ? (regB[dataWidth-1] != extOperand[dataWidth-1])
                            : (regB[dataWidth-1] == extOperand[dataWidth-1]))
                     && (result[dataWidth-1] != regB[dataWidth-1]);

  always_comb
  begin
    if (issueSigned)
    begin
      nextOvf = signedOvf;
      nextNeg = result[dataWidth-1];
    end
    else
    begin
      // Unsigned: carry flags an add, borrow flags a subtract
      nextOvf = carryOut && !isSub;
      nextNeg = carryOut && isSub;
    end
  end

  ////////////////////////////////////////////////////////////
  // Flag registers, touched only by Add and Sub

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      overflowFlag <= 1'b0;
      negFlag      <= 1'b0;
    end
    else if (resultValid)
    begin
      overflowFlag <= nextOvf;
      negFlag      <= nextNeg;
    end
  end

endmodule

//--- source/calcDecode.sv
////////////////////////////////////////////////////////////
// Command decode stage: samples one command per strobe,
// drops it while busy and issues it for one cycle
////////////////////////////////////////////////////////////

module calcDecode (
  input  logic            CLK,
  input  logic            RST,
  input  logic            cmdValid,
  input  calcPkg::opcode_t opcode,
  input  calcPkg::regSel_t regSel,
  input  logic            signedMode,
  input  calcPkg::byte_t   operand,
  input  logic            busy,
  output logic            issueValid,
  output calcPkg::opcode_t issueOp,
  output calcPkg::regSel_t issueSel,
  output logic            issueSigned,
  output calcPkg::byte_t   issueOperand,
  output calcPkg::word_t   extOperand
);
  import calcPkg::*;

  logic accept;

  // No back-pressure, a command during busy is lost
  assign accept = cmdValid && !busy;

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      issueValid <= 1'b0;
    end
    else
    begin
      issueValid <= accept;
    end
  end

  // Command fields, held until the next accepted command
  always_ff @(posedge CLK)
  begin
    if (accept)
    begin
      issueOp      <= opcode;
      issueSel     <= regSel;
      issueSigned  <= signedMode;
      issueOperand <= operand;
    end
  end

  // Sign or zero extension of the operand byte
  assign extOperand = {{(dataWidth - byteWidth){issueSigned & issueOperand[byteWidth-1]}},
                       issueOperand};

  // Busy feedback from the top must block back-to-back issues
  assert property (@(posedge CLK) disable iff (!RST)
    issueValid |=> !issueValid);

endmodule

//--- source/calcMultiplier.sv
////////////////////////////////////////////////////////////
// Serial shift-add multiplier, one operand bit per cycle;
// leaves the low half of A times the extended operand
////////////////////////////////////////////////////////////

module calcMultiplier (
  input  logic             CLK,
  input  logic             RST,
  input  logic             issueValid,
  input  calcPkg::opcode_t issueOp,
  input  logic             issueSigned,
  input  calcPkg::word_t   regA,
  input  calcPkg::byte_t   issueOperand,
  output logic             resultValid,
  output calcPkg::word_t   result,
  output logic             running
);
  import calcPkg::*;

  typedef enum logic {
    mulIdle,
    mulRun
  } mulState_t;

  mulState_t               state;
  logic [mulStepWidth-1:0] stepCount;
  logic                    lastStep;
  logic                    start;
  word_t                   mcand;
  byte_t                   multiplier;
  logic                    runSigned;
  word_t                   partial;

  assign start    = issueValid && (issueOp == opMul) && (state == mulIdle);
  assign lastStep = (stepCount == mulStepWidth'(mulSteps - 1));
  assign running  = (state == mulRun);

  // A shifted to the weight of the current operand bit
  assign partial = multiplier[stepCount] ? (mcand << stepCount) : '0;

  ////////////////////////////////////////////////////////////
  // Control: idle/run FSM and step counter

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      state       <= mulIdle;
      stepCount   <= '0;
      resultValid <= 1'b0;
    end
    else
    begin
      resultValid <= 1'b0;
      case (state)
        mulIdle:
        begin
          if (start)
          begin
            // Bit 0 is handled on the start edge itself
            state     <= mulRun;
            stepCount <= mulStepWidth'(1);
          end
        end
        mulRun:
        begin
          stepCount <= stepCount + 1'b1;
          if (lastStep)
          begin
            state       <= mulIdle;
            resultValid <= 1'b1;
          end
        end
        default: state <= mulIdle;
      endcase
    end
  end

  // Datapath: accumulator and latched operands
  always_ff @(posedge CLK)
  begin
    if (start)
    begin
      mcand      <= regA;
      multiplier <= issueOperand;
      runSigned  <= issueSigned;
      result     <= issueOperand[0] ? regA : '0;
    end
    else if (running)
    begin
      // Bit 7 carries weight -128 when signed
      if (lastStep && runSigned)
        result <= result - partial;
      else
        result <= result + partial;
    end
  end

  // The top must hold off every command until the product is back
  assert property (@(posedge CLK) disable iff (!RST)
    (issueValid && issueOp == opMul) |-> !running);

endmodule

//--- source/calcPkg.sv
////////////////////////////////////////////////////////////
// Widths, word types and opcode encoding of the register
// calculator, imported by every RTL module of the design
////////////////////////////////////////////////////////////

package calcPkg;

  // Register and operand widths
  localparam int dataWidth = 16;
  localparam int byteWidth = 8;

  // Serial multiplier, one operand bit per cycle
  localparam int mulSteps     = 8;
  localparam int mulStepWidth = $clog2(mulSteps);

  // Full register value
  typedef logic [dataWidth-1:0] word_t;

  // Operand or output byte
  typedef logic [byteWidth-1:0] byte_t;

  // Byte selector
  //   0 = A low, 1 = A high, 2 = B low, 3 = B high
  typedef logic [1:0] regSel_t;

  ////////////////////////////////////////////////////////////
  // Command opcodes
  ////////////////////////////////////////////////////////////

  // Load  writes the operand byte into A or B
  // Add   B = B + extended operand
  // Sub   B = B - extended operand
  // Mul   B = low half of A * extended operand
  // Read  picks the byte shown on the output
  typedef enum logic [2:0] {
    opLoad = 3'd0,
    opAdd  = 3'd1,
    opSub  = 3'd2,
    opMul  = 3'd3,
    opRead = 3'd4
  } opcode_t;

endpackage

//--- source/calcRegisterFile.sv
////////////////////////////////////////////////////////////
// Registers A and B with byte loads, write-back of results
// and the read select that drives the output byte
////////////////////////////////////////////////////////////

module calcRegisterFile (
  input  logic             CLK,
  input  logic             RST,
  input  logic             issueValid,
  input  calcPkg::opcode_t issueOp,
  input  calcPkg::regSel_t issueSel,
  input  calcPkg::byte_t   issueOperand,
  input  logic             arithValid,
  input  calcPkg::word_t   arithResult,
  input  logic             mulValid,
  input  calcPkg::word_t   mulResult,
  output calcPkg::word_t   regA,
  output calcPkg::word_t   regB,
  output calcPkg::byte_t   dataOut
);
  import calcPkg::*;

  regSel_t readSel;
  logic    loadStrobe;

  assign loadStrobe = issueValid && (issueOp == opLoad);

  ////////////////////////////////////////////////////////////
  // Register updates

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      regA    <= '0;
      regB    <= '0;
      readSel <= '0;
    end
    else
    begin
      if (loadStrobe)
      begin
        case (issueSel)
          2'd0: regA[byteWidth-1:0]         <= issueOperand;
          2'd1: regA[dataWidth-1:byteWidth] <= issueOperand;
          2'd2: regB[byteWidth-1:0]         <= issueOperand;
          default: regB[dataWidth-1:byteWidth] <= issueOperand;
        endcase
      end
      // Results always land in B
      if (arithValid)
        regB <= arithResult;
      else if (mulValid)
        regB <= mulResult;
      if (issueValid && issueOp == opRead)
        readSel <= issueSel;
    end
  end

  // Output byte mux
  always_comb
  begin
    case (readSel)
      2'd0: dataOut = regA[byteWidth-1:0];
      2'd1: dataOut = regA[dataWidth-1:byteWidth];
      2'd2: dataOut = regB[byteWidth-1:0];
      default: dataOut = regB[dataWidth-1:byteWidth];
    endcase
  end

  // Only one execute unit may return a result per cycle
  assert property (@(posedge CLK) disable iff (!RST)
    !(arithValid && mulValid));

endmodule

//--- source/calcTop.sv
////////////////////////////////////////////////////////////
// Calculator top: decode, execute and write-back stages,
// plus the busy and done status seen by the host
////////////////////////////////////////////////////////////

module calcTop (
  input  logic             CLK,
  input  logic             RST,
  input  logic             cmdValid,
  input  calcPkg::opcode_t opcode,
  input  calcPkg::regSel_t regSel,
  input  logic             signedMode,
  input  calcPkg::byte_t   operand,
  output calcPkg::byte_t   dataOut,
  output logic             overflowFlag,
  output logic             negFlag,
  output logic             busy,
  output logic             done
);
  import calcPkg::*;

  logic     issueValid;
  opcode_t  issueOp;
  regSel_t  issueSel;
  logic     issueSigned;
  byte_t    issueOperand;
  word_t    extOperand;
  logic     arithValid;
  word_t    arithResult;
  logic     mulValid;
  word_t    mulResult;
  logic     running;
  word_t    regA;
  word_t    regB;
  logic     busyHold;
  logic     quickOp;

  ////////////////////////////////////////////////////////////
  // Stages

  calcDecode decode (
    .CLK          (CLK),
    .RST          (RST),
    .cmdValid     (cmdValid),
    .opcode       (opcode),
    .regSel       (regSel),
    .signedMode   (signedMode),
    .operand      (operand),
    .busy         (busy),
    .issueValid   (issueValid),
    .issueOp      (issueOp),
    .issueSel     (issueSel),
    .issueSigned  (issueSigned),
    .issueOperand (issueOperand),
    .extOperand   (extOperand)
  );

  calcArith arith (
    .CLK          (CLK),
    .RST          (RST),
    .issueValid   (issueValid),
    .issueOp      (issueOp),
    .issueSigned  (issueSigned),
    .regB         (regB),
    .extOperand   (extOperand),
    .resultValid  (arithValid),
    .result       (arithResult),
    .overflowFlag (overflowFlag),
    .negFlag      (negFlag)
  );

  calcMultiplier multiplier (
    .CLK          (CLK),
    .RST          (RST),
    .issueValid   (issueValid),
    .issueOp      (issueOp),
    .issueSigned  (issueSigned),
    .regA         (regA),
    .issueOperand (issueOperand),
    .resultValid  (mulValid),
    .result       (mulResult),
    .running      (running)
  );

  calcRegisterFile regFile (
    .CLK          (CLK),
    .RST          (RST),
    .issueValid   (issueValid),
    .issueOp      (issueOp),
    .issueSel     (issueSel),
    .issueOperand (issueOperand),
    .arithValid   (arithValid),
    .arithResult  (arithResult),
    .mulValid     (mulValid),
    .mulResult    (mulResult),
    .regA         (regA),
    .regB         (regB),
    .dataOut      (dataOut)
  );

  ////////////////////////////////////////////////////////////
  // Status

  // Load and Read finish in the issue cycle, like Add and Sub
  assign quickOp = issueValid && (issueOp == opLoad || issueOp == opRead);

  // Busy covers issue, the whole multiply and the done cycle
  assign busy = issueValid || busyHold;

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      busyHold <= 1'b0;
      done     <= 1'b0;
    end
    else
    begin
      busyHold <= issueValid || running || mulValid;
      // One cycle after the register write
      done     <= quickOp || arithValid || mulValid;
    end
  end

endmodule

//--- sources.f
source/calcPkg.sv
source/calcDecode.sv
source/calcArith.sv
source/calcMultiplier.sv
source/calcRegisterFile.sv
source/calcTop.sv
verification/calcTb.sv

//--- verification/calcTb.sv
////////////////////////////////////////////////////////////
// Testbench for the register calculator: directed and random
// commands, checked against a reference model on each done
////////////////////////////////////////////////////////////

module calcTb;
  timeunit 1ns;
  timeprecision 100ps;

  import calcPkg::*;

  localparam int unsigned randSeed = 32'h4a73;
  localparam int resetCycles   = 5;
  localparam int randomCmds    = 300;
  localparam int directedCmds  = 80;
  localparam int watchdogCycles = (randomCmds + directedCmds) * 12 + resetCycles;

  // Architectural state seen from outside
  typedef struct packed {
    word_t   a;
    word_t   b;
    logic    ovf;
    logic    neg;
    regSel_t readSel;
  } calcState_t;

  logic    CLK;
  logic    RST;
  logic    cmdValid;
  opcode_t opcode;
  regSel_t regSel;
  logic    signedMode;
  byte_t   operand;
  byte_t   dataOut;
  logic    overflowFlag;
  logic    negFlag;
  logic    busy;
  logic    done;

  calcState_t model;
  int         issuedCount = 0;
  int         doneCount = 0;

  calcTop i_dut (
    .CLK          (CLK),
    .RST          (RST),
    .cmdValid     (cmdValid),
    .opcode       (opcode),
    .regSel       (regSel),
    .signedMode   (signedMode),
    .operand      (operand),
    .dataOut      (dataOut),
    .overflowFlag (overflowFlag),
    .negFlag      (negFlag),
    .busy         (busy),
    .done         (done)
  );

  initial
  begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic abortRun(input string msg);
    $display("test failed");
    $display("%s", msg);
    $fatal(1);
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model

  function automatic calcState_t referenceStep(calcState_t s, opcode_t op, regSel_t sel,
                                               logic sgn, byte_t val);
    calcState_t  n;
    int          bVal;
    int          oVal;
    int          sum;
    word_t       ext;
    logic [31:0] prod;
    n    = s;
    bVal = sgn ? int'($signed(s.b)) : int'(s.b);
    oVal = sgn ? int'($signed(val)) : int'(val);
    ext  = sgn ? {{8{val[7]}}, val} : {8'h00, val};
    case (op)
      opLoad:
      begin
        case (sel)
          2'd0: n.a[7:0] = val;
          2'd1: n.a[15:8] = val;
          2'd2: n.b[7:0] = val;
          default: n.b[15:8] = val;
        endcase
      end
      opAdd, opSub:
      begin
        sum = (op == opAdd) ? bVal + oVal : bVal - oVal;
        n.b = sum[15:0];
        if (sgn)
        begin
          n.ovf = (sum > 32767) || (sum < -32768);
          n.neg = sum[15];
        end
        else
        begin
          // Carry of an add, borrow of a subtract
          n.ovf = (op == opAdd) && (sum > 65535);
          n.neg = (op == opSub) && (sum < 0);
        end
      end
      opMul:
      begin
        prod = {16'h0000, s.a} * {16'h0000, ext};
        n.b  = prod[15:0];
      end
      opRead: n.readSel = sel;
      default: n = s;
    endcase
    return n;
  endfunction

  function automatic byte_t expectedByte(calcState_t s);
    case (s.readSel)
      2'd0: return s.a[7:0];
      2'd1: return s.a[15:8];
      2'd2: return s.b[7:0];
      default: return s.b[15:8];
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Comparison, sampled mid-cycle

  always @(negedge CLK)
  begin
    if (RST)
    begin
      if (issuedCount != doneCount)
      begin
        assert (busy) else abortRun("busy dropped while a command was outstanding");
      end
      else
      begin
        assert (!busy) else abortRun("busy stayed high with no command outstanding");
      end
      if (done)
      begin
        assert (doneCount < issuedCount) else abortRun("done pulsed with no accepted command");
        doneCount++;
        assert (i_dut.regA == model.a)
          else abortRun($sformatf("error: regA is 0x%h, expected 0x%h", i_dut.regA, model.a));
        assert (i_dut.regB == model.b)
          else abortRun($sformatf("error: regB is 0x%h, expected 0x%h", i_dut.regB, model.b));
        assert (dataOut == expectedByte(model))
          else abortRun($sformatf("error: dataOut is 0x%h, expected 0x%h",
                                  dataOut, expectedByte(model)));
        assert (overflowFlag == model.ovf)
          else abortRun($sformatf("error: overflowFlag is 0x%h, expected 0x%h",
                                  overflowFlag, model.ovf));
        assert (negFlag == model.neg)
          else abortRun($sformatf("error: negFlag is 0x%h, expected 0x%h", negFlag, model.neg));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus tasks, all called 1 ns after a rising edge

  task automatic waitCycles(input int n);
    repeat (n) @(posedge CLK);
    #1;
  endtask

  task automatic sendCommand(input opcode_t op, input regSel_t sel, input logic sgn,
                             input byte_t val);
    while (busy)
    begin
      @(posedge CLK);
      #1;
    end
    cmdValid   = 1'b1;
    opcode     = op;
    regSel     = sel;
    signedMode = sgn;
    operand    = val;
    @(posedge CLK);
    #1;
    cmdValid    = 1'b0;
    model       = referenceStep(model, op, sel, sgn, val);
    issuedCount++;
  endtask

  // Must be dropped by the DUT, so the model stays as it is
  task automatic sendWhileBusy(input opcode_t op, input regSel_t sel, input byte_t val);
    assert (busy) else abortRun("stray command was not driven inside a busy period");
    cmdValid   = 1'b1;
    opcode     = op;
    regSel     = sel;
    signedMode = 1'b1;
    operand    = val;
    @(posedge CLK);
    #1;
    cmdValid = 1'b0;
  endtask

  task automatic loadA(input word_t value);
    sendCommand(opLoad, 2'd0, 1'b0, value[7:0]);
    sendCommand(opLoad, 2'd1, 1'b0, value[15:8]);
  endtask

  task automatic loadB(input word_t value);
    sendCommand(opLoad, 2'd2, 1'b0, value[7:0]);
    sendCommand(opLoad, 2'd3, 1'b0, value[15:8]);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial
  begin
    int i;
    void'($urandom(randSeed));
    RST        = 1'b0;
    cmdValid   = 1'b0;
    opcode     = opLoad;
    regSel     = 2'd0;
    signedMode = 1'b0;
    operand    = 8'h00;
    model      = '0;
    repeat (resetCycles) @(posedge CLK);
    #1;
    RST = 1'b1;
    assert (dataOut == 8'h00)
      else abortRun($sformatf("error: dataOut is 0x%h, expected 0x00", dataOut));
    assert (!busy) else abortRun("busy is high after reset");

    // Load and read back each byte
    for (i = 0; i < 4; i++)
    begin
      sendCommand(opLoad, regSel_t'(i), 1'b0, byte_t'(8'h5A + i * 8'h21));
      sendCommand(opRead, regSel_t'(i), 1'b0, 8'h00);
    end

    // Unsigned carry and borrow
    loadB(16'hFFF0);
    sendCommand(opAdd, 2'd0, 1'b0, 8'h20);
    sendCommand(opAdd, 2'd0, 1'b0, 8'h05);
    loadB(16'h0005);
    sendCommand(opSub, 2'd0, 1'b0, 8'h10);
    sendCommand(opSub, 2'd0, 1'b0, 8'h03);

    // Signed overflow at the 7FFF and 8000 boundaries
    sendCommand(opRead, 2'd3, 1'b0, 8'h00);
    loadB(16'h7FFF);
    sendCommand(opAdd, 2'd0, 1'b1, 8'h01);
    loadB(16'h8000);
    sendCommand(opSub, 2'd0, 1'b1, 8'h01);
    loadB(16'h8000);
    sendCommand(opAdd, 2'd0, 1'b1, 8'hFF);
    loadB(16'h7FFF);
    sendCommand(opSub, 2'd0, 1'b1, 8'hFF);
    loadB(16'h0010);
    sendCommand(opAdd, 2'd0, 1'b1, 8'hF0);
    sendCommand(opSub, 2'd0, 1'b1, 8'h20);

    // Multiply in both modes, flags left alone
    loadA(16'h1234);
    sendCommand(opRead, 2'd2, 1'b0, 8'h00);
    sendCommand(opMul, 2'd0, 1'b0, 8'hFB);
    sendCommand(opMul, 2'd0, 1'b1, 8'hFB);
    loadA(16'hFFFF);
    sendCommand(opMul, 2'd0, 1'b1, 8'h80);
    sendCommand(opMul, 2'd0, 1'b0, 8'h80);

    // Commands during a multiply are dropped, even in its done cycle
    loadA(16'h0BCD);
    sendCommand(opMul, 2'd0, 1'b1, 8'h97);
    sendWhileBusy(opLoad, 2'd0, 8'hEE);
    waitCycles(3);
    sendWhileBusy(opAdd, 2'd2, 8'h7F);
    while (!done)
    begin
      @(posedge CLK);
      #1;
    end
    sendWhileBusy(opRead, 2'd1, 8'h00);

    // Random mix
    for (i = 0; i < randomCmds; i++)
    begin
      sendCommand(opcode_t'($urandom_range(4, 0)), regSel_t'($urandom_range(3, 0)),
                  1'($urandom_range(1, 0)), byte_t'($urandom()));
    end

    while (doneCount != issuedCount)
      @(posedge CLK);
    waitCycles(4);
    $display("test passed");
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (watchdogCycles) @(posedge CLK);
    abortRun("watchdog expired before all commands completed");
  end

endmodule
